// ==== hw/mera_pkg.sv ====
`default_nettype none

package mera_pkg;

	// ------------------------------
	// sizes
	// ------------------------------

	// installed memory, words
	localparam int mem_words = 4096;
	// memory index width
	localparam int mem_aw = 12;
	// length of the clear level, cycles
	localparam int clear_cycles = 16;
	// clear counter width, must hold clear_cycles
	localparam int clear_cw = $clog2(clear_cycles + 1);

	// ------------------------------
	// basic types
	// ------------------------------

	// data word on the system bus
	typedef logic [15:0] word_t;
	// bus address, full 16 bits even if less memory is installed
	typedef logic [15:0] addr_t;

	// panel operations
	typedef enum logic [2:0] {
		op_load    = 3'd0,
		op_store   = 3'd1,
		op_fetch   = 3'd2,
		op_read_ar = 3'd3,
		op_clear   = 3'd4
	} op_t;

	// ------------------------------
	// channel payloads
	// ------------------------------

	// operator command, 19 bits
	typedef struct packed {
		op_t   op;
		// load value or store data
		word_t data;
	} panel_cmd_t;

	// decoded operation for execute, 21 bits
	typedef struct packed {
		op_t   op;
		word_t data;
		// memory write cycle needed
		logic  wr;
		// memory read cycle needed
		logic  rd;
	} exec_op_t;

	// result word back to the operator, 20 bits
	typedef struct packed {
		op_t   op;
		word_t data;
		// nomem hit, data holds the offending address
		logic  alarm;
	} panel_res_t;

endpackage

`default_nettype wire

// ==== hw/power_seq.sv ====
`timescale 1ns/100ps
`default_nettype none

module power_seq import mera_pkg::*; (
	input  wire  CLK_EXT,
	input  wire  rst,
	// master clear request from execute
	input  wire  clear_req,
	// clear level
	output logic clm,
	// power good
	output logic pon
);

	// ------------------------------
	// clear counter
	// ------------------------------

	// counts down the remaining clear cycles
	logic [clear_cw-1:0] cnt;

	// clear held while anything is left to count
	assign clm = (cnt != '0);

	always_ff @(posedge CLK_EXT) begin
		if (rst || clear_req) begin
			// (re)start the whole clear period
			cnt <= clear_cw'(clear_cycles);
			pon <= 1'b0;
		end else if (clm) begin
			cnt <= cnt - 1'b1;
			// power not good yet
			pon <= 1'b0;
		end else begin
			// clear over, power good
			pon <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/panel_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module panel_decode import mera_pkg::*; (
	input  wire        CLK_EXT,
	input  wire        rst,
	// clear level, blocks new commands
	input  wire        clm,
	// operator command channel
	input  panel_cmd_t cmd,
	input  wire        cmd_valid,
	output logic       cmd_ready,
	// decoded operation to execute
	output exec_op_t   dec,
	output logic       dec_valid,
	input  wire        dec_ready
);

	// ------------------------------
	// one-entry stage
	// ------------------------------

	logic     full;
	exec_op_t dec_q;
	logic     cmd_fire;

	// room if empty or the held entry leaves this cycle
	assign cmd_ready = !clm && (!full || dec_ready);
	assign cmd_fire  = cmd_valid && cmd_ready;

	assign dec       = dec_q;
	assign dec_valid = full;

	// stage occupancy
	always_ff @(posedge CLK_EXT) begin
		if (rst) begin
			full <= 1'b0;
		end else if (cmd_fire) begin
			full <= 1'b1;
		end else if (dec_ready) begin
			// entry taken by execute
			full <= 1'b0;
		end
	end

	// payload and strobes
	always_ff @(posedge CLK_EXT) begin
		if (cmd_fire) begin
			dec_q.op   <= cmd.op;
			dec_q.data <= cmd.data;
			// only store writes memory
			dec_q.wr   <= (cmd.op == op_store);
			// only fetch reads memory
			dec_q.rd   <= (cmd.op == op_fetch);
		end
	end

endmodule

`default_nettype wire

// ==== hw/bus_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_execute import mera_pkg::*; (
	input  wire        CLK_EXT,
	input  wire        rst,
	input  wire        clm,
	// decoded operation from decode
	input  exec_op_t   dec,
	input  wire        dec_valid,
	output logic       dec_ready,
	// system bus towards memory
	output addr_t      mem_addr,
	output word_t      mem_wdata,
	output logic       mem_we,
	output logic       mem_re,
	input  word_t      mem_rdata,
	// master clear request, one cycle
	output logic       clear_req,
	// result towards the output register
	output panel_res_t exe,
	output logic       exe_valid,
	input  wire        exe_ready
);

	typedef enum logic [1:0] {
		st_idle,
		st_mem_wait,
		st_clr_wait,
		st_hold
	} state_t;

	state_t     state;
	// address register
	addr_t      ar;
	panel_res_t exe_q;
	logic       dec_fire;
	logic       nomem;
	logic       mem_op;

	// ------------------------------
	// handshake and bus strobes
	// ------------------------------

	// new op when idle, or when the held result leaves now
	assign dec_ready = !clm && (state == st_idle || (state == st_hold && exe_ready));
	assign dec_fire  = dec_valid && dec_ready;

	// stop-on-nomem check, only place it is made
	assign nomem  = (ar >= addr_t'(mem_words));
	assign mem_op = dec.wr || dec.rd;

	// memory cycle issued on the dec transfer itself
	assign mem_addr  = ar;
	assign mem_wdata = dec.data;
	assign mem_we    = dec_fire && dec.wr && !nomem;
	assign mem_re    = dec_fire && dec.rd && !nomem;

	assign clear_req = dec_fire && (dec.op == op_clear);

	assign exe       = exe_q;
	assign exe_valid = (state == st_hold);

	// ------------------------------
	// FSM
	// ------------------------------

	always_ff @(posedge CLK_EXT) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle, st_hold: begin
					if (dec_fire) begin
						if (dec.op == op_clear) begin
							state <= st_clr_wait;
						end else if (mem_op && !nomem) begin
							state <= st_mem_wait;
						end else begin
							// load, read_ar and nomem answer right away
							state <= st_hold;
						end
					end else if (state == st_hold && exe_ready) begin
						state <= st_idle;
					end
				end
				// ram answers one cycle after the strobe
				st_mem_wait: state <= st_hold;
				// result once the clear level is gone
				st_clr_wait: begin
					if (!clm) begin
						state <= st_hold;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// ------------------------------
	// address register
	// ------------------------------

	always_ff @(posedge CLK_EXT) begin
		if (rst || clm) begin
			ar <= '0;
		end else if (dec_fire) begin
			if (dec.op == op_load) begin
				ar <= dec.data;
			end else if (mem_op && !nomem) begin
				// auto increment after a good store or fetch
				ar <= ar + 16'd1;
			end
		end
	end

	// ------------------------------
	// result payload
	// ------------------------------

	always_ff @(posedge CLK_EXT) begin
		if (dec_fire) begin
			exe_q.op    <= dec.op;
			exe_q.alarm <= mem_op && nomem;
			case (dec.op)
				op_load: exe_q.data <= dec.data;
				// fetch data replaced from ram later, unless nomem
				op_store, op_fetch, op_read_ar: exe_q.data <= ar;
				default: exe_q.data <= '0;
			endcase
		end else if (state == st_mem_wait && exe_q.op == op_fetch) begin
			exe_q.data <= mem_rdata;
		end
	end

endmodule

`default_nettype wire

// ==== hw/main_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module main_mem import mera_pkg::*; (
	input  wire   CLK_EXT,
	// system bus side
	input  addr_t mem_addr,
	input  word_t mem_wdata,
	input  wire   mem_we,
	input  wire   mem_re,
	output word_t mem_rdata
);

	// ------------------------------
	// storage
	// ------------------------------

	// installed words only, upper address bits checked in execute
	word_t mem [mem_words];

	logic [mem_aw-1:0] idx;

	assign idx = mem_addr[mem_aw-1:0];

	// single port, write has priority of use, read registered
	always_ff @(posedge CLK_EXT) begin
		if (mem_we) begin
			mem[idx] <= mem_wdata;
		end
		if (mem_re) begin
			// data valid the cycle after the strobe
			mem_rdata <= mem[idx];
		end
	end

endmodule

`default_nettype wire

// ==== hw/panel_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module panel_result import mera_pkg::*; (
	input  wire        CLK_EXT,
	input  wire        rst,
	// from execute
	input  panel_res_t exe,
	input  wire        exe_valid,
	output logic       exe_ready,
	// to the operator
	output panel_res_t res,
	output logic       res_valid,
	input  wire        res_ready
);

	// ------------------------------
	// output holding register
	// ------------------------------

	logic       full;
	panel_res_t res_q;
	logic       exe_fire;

	// take a new result while the old one leaves
	assign exe_ready = !full || res_ready;
	assign exe_fire  = exe_valid && exe_ready;

	assign res       = res_q;
	assign res_valid = full;

	always_ff @(posedge CLK_EXT) begin
		if (rst) begin
			full <= 1'b0;
		end else if (exe_fire) begin
			full <= 1'b1;
		end else if (res_ready) begin
			// operator took it
			full <= 1'b0;
		end
	end

	// payload, held while the operator stalls
	always_ff @(posedge CLK_EXT) begin
		if (exe_fire) begin
			res_q <= exe;
		end
	end

endmodule

`default_nettype wire

// ==== hw/mera_panel_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mera_panel_top import mera_pkg::*; (
	input  wire        CLK_EXT,
	input  wire        rst,
	// operator commands
	input  panel_cmd_t cmd,
	input  wire        cmd_valid,
	output logic       cmd_ready,
	// operator results
	output panel_res_t res,
	output logic       res_valid,
	input  wire        res_ready,
	// power good
	output logic       pon
);

	// ------------------------------
	// power supply
	// ------------------------------

	logic clm;
	logic clear_req;

	power_seq i_power_seq (
		.CLK_EXT   (CLK_EXT),
		.rst       (rst),
		.clear_req (clear_req),
		.clm       (clm),
		.pon       (pon)
	);

	// ------------------------------
	// decode
	// ------------------------------

	exec_op_t dec;
	logic     dec_valid;
	logic     dec_ready;

	panel_decode i_panel_decode (
		.CLK_EXT   (CLK_EXT),
		.rst       (rst),
		.clm       (clm),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.dec       (dec),
		.dec_valid (dec_valid),
		.dec_ready (dec_ready)
	);

	// ------------------------------
	// execute and memory
	// ------------------------------

	addr_t      mem_addr;
	word_t      mem_wdata;
	word_t      mem_rdata;
	logic       mem_we;
	logic       mem_re;
	panel_res_t exe;
	logic       exe_valid;
	logic       exe_ready;

	bus_execute i_bus_execute (
		.CLK_EXT   (CLK_EXT),
		.rst       (rst),
		.clm       (clm),
		.dec       (dec),
		.dec_valid (dec_valid),
		.dec_ready (dec_ready),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_we    (mem_we),
		.mem_re    (mem_re),
		.mem_rdata (mem_rdata),
		.clear_req (clear_req),
		.exe       (exe),
		.exe_valid (exe_valid),
		.exe_ready (exe_ready)
	);

	main_mem i_main_mem (
		.CLK_EXT   (CLK_EXT),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_we    (mem_we),
		.mem_re    (mem_re),
		.mem_rdata (mem_rdata)
	);

	// ------------------------------
	// result
	// ------------------------------

	panel_result i_panel_result (
		.CLK_EXT   (CLK_EXT),
		.rst       (rst),
		.exe       (exe),
		.exe_valid (exe_valid),
		.exe_ready (exe_ready),
		.res       (res),
		.res_valid (res_valid),
		.res_ready (res_ready)
	);

endmodule

`default_nettype wire

// ==== dv/tb_vectors.svh ====
// name, op, cmd data, expected data, expected alarm, random res_ready stalls
// expected data follows the panel result rules, ar is zero after reset

task automatic load_table;
	// ------------------------------
	// load and read back
	// ------------------------------
	add_row("load_base",        op_load,    16'h0100, 16'h0100, 1'b0, 1'b0);
	add_row("read_ar_base",     op_read_ar, 16'h0000, 16'h0100, 1'b0, 1'b0);

	// store burst, then fetch it back in order
	add_row("store_a",          op_store,   16'hbeef, 16'h0100, 1'b0, 1'b0);
	add_row("store_b",          op_store,   16'h1234, 16'h0101, 1'b0, 1'b0);
	add_row("store_c",          op_store,   16'ha5a5, 16'h0102, 1'b0, 1'b0);
	add_row("reload_base",      op_load,    16'h0100, 16'h0100, 1'b0, 1'b0);
	add_row("fetch_a",          op_fetch,   16'h0000, 16'hbeef, 1'b0, 1'b0);
	add_row("fetch_b",          op_fetch,   16'h0000, 16'h1234, 1'b0, 1'b0);
	add_row("fetch_c",          op_fetch,   16'h0000, 16'ha5a5, 1'b0, 1'b0);
	add_row("read_ar_inc",      op_read_ar, 16'h0000, 16'h0103, 1'b0, 1'b0);

	// ------------------------------
	// nomem
	// ------------------------------
	add_row("load_nomem",       op_load,    16'h1000, 16'h1000, 1'b0, 1'b0);
	add_row("fetch_nomem",      op_fetch,   16'h0000, 16'h1000, 1'b1, 1'b0);
	add_row("store_nomem",      op_store,   16'hdead, 16'h1000, 1'b1, 1'b0);
	add_row("read_ar_nomem",    op_read_ar, 16'h0000, 16'h1000, 1'b0, 1'b0);

	// master clear keeps memory, zeroes ar
	add_row("clear",            op_clear,   16'h0000, 16'h0000, 1'b0, 1'b0);
	add_row("read_ar_clear",    op_read_ar, 16'h0000, 16'h0000, 1'b0, 1'b0);
	add_row("load_after_clear", op_load,    16'h0101, 16'h0101, 1'b0, 1'b0);
	add_row("fetch_kept",       op_fetch,   16'h0000, 16'h1234, 1'b0, 1'b0);

	// ------------------------------
	// back to back under stalls
	// ------------------------------
	add_row("load_top",         op_load,    16'h0ffe, 16'h0ffe, 1'b0, 1'b1);
	add_row("store_x",          op_store,   16'h1111, 16'h0ffe, 1'b0, 1'b1);
	add_row("store_y",          op_store,   16'h2222, 16'h0fff, 1'b0, 1'b1);
	add_row("store_over",       op_store,   16'h3333, 16'h1000, 1'b1, 1'b1);
	add_row("load_back",        op_load,    16'h0ffe, 16'h0ffe, 1'b0, 1'b1);
	add_row("fetch_x",          op_fetch,   16'h0000, 16'h1111, 1'b0, 1'b1);
	add_row("fetch_y",          op_fetch,   16'h0000, 16'h2222, 1'b0, 1'b1);
	add_row("fetch_over",       op_fetch,   16'h0000, 16'h1000, 1'b1, 1'b1);
	add_row("read_ar_end",      op_read_ar, 16'h0000, 16'h1000, 1'b0, 1'b1);
	add_row("load_again",       op_load,    16'h0100, 16'h0100, 1'b0, 1'b1);
	add_row("fetch_again",      op_fetch,   16'h0000, 16'hbeef, 1'b0, 1'b1);
endtask

// ==== dv/tb_mera_panel.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mera_panel import mera_pkg::*; ();

	// ------------------------------
	// clock, reset and DUT
	// ------------------------------

	logic       CLK_EXT;
	logic       rst;
	panel_cmd_t cmd;
	logic       cmd_valid;
	logic       cmd_ready;
	panel_res_t res;
	logic       res_valid;
	logic       res_ready;
	logic       pon;

	// 4 ns period
	always #2 CLK_EXT = ~CLK_EXT;

	mera_panel_top i_mera_panel_top (
		.CLK_EXT   (CLK_EXT),
		.rst       (rst),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.res       (res),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.pon       (pon)
	);

	// ------------------------------
	// table and bookkeeping
	// ------------------------------

	typedef struct {
		string      name;
		panel_cmd_t cmd;
		panel_res_t exp;
		// random res_ready, sent back to back
		logic       stall;
	} test_row_t;

	test_row_t rows [$];
	// cycle count at each command transfer
	int        accept_cyc [$];
	int        seed;
	int        cycles;
	int        cycle_limit;
	// results taken so far, also index of the next one
	int        done_count;
	int        pass_count;
	int        fail_count;

	task automatic add_row(input string name, input op_t op, input word_t data,
		input word_t exp_data, input logic alarm, input logic stall);
		test_row_t r;
		r.name      = name;
		r.cmd.op    = op;
		r.cmd.data  = data;
		r.exp.op    = op;
		r.exp.data  = exp_data;
		r.exp.alarm = alarm;
		r.stall     = stall;
		rows.push_back(r);
	endtask

	`include "tb_vectors.svh"

	// ------------------------------
	// compare tasks
	// ------------------------------

	function automatic string fmt_res(input panel_res_t r);
		return $sformatf("op=%0d data=%h alarm=%b", r.op, r.data, r.alarm);
	endfunction

	task automatic check_res(input string name, input panel_res_t exp, input panel_res_t act);
		if (act === exp) begin
			pass_count++;
			$display("PASSED %s %s", name, fmt_res(act));
		end else begin
			fail_count++;
			$display("FAILED %s expected %s actual %s", name, fmt_res(exp), fmt_res(act));
		end
	endtask

	task automatic check_pon(input string name, input logic exp, input logic act);
		if (act === exp) begin
			pass_count++;
			$display("PASSED %s pon=%b", name, act);
		end else begin
			fail_count++;
			$display("FAILED %s expected pon=%b actual pon=%b", name, exp, act);
		end
	endtask

	// lo equal to hi for the fixed cases
	task automatic check_latency(input string name, input int lo, input int hi, input int act);
		if (act < lo || act > hi) begin
			fail_count++;
			$display("FAILED %s latency expected %0d..%0d actual %0d", name, lo, hi, act);
		end
	endtask

	// idle pipe: 3 cycles, one more for a real memory cycle
	function automatic int expected_latency(input panel_res_t r);
		if ((r.op == op_store || r.op == op_fetch) && !r.alarm) begin
			return 4;
		end
		return 3;
	endfunction

	// ------------------------------
	// reference model of ar and memory
	// ------------------------------

	task automatic check_table;
		addr_t      ar_m;
		word_t      mem_m [addr_t];
		panel_res_t r;
		ar_m = '0;
		foreach (rows[i]) begin
			r.op    = rows[i].cmd.op;
			r.data  = '0;
			r.alarm = 1'b0;
			case (rows[i].cmd.op)
				op_load: begin
					ar_m   = rows[i].cmd.data;
					r.data = rows[i].cmd.data;
				end
				op_read_ar: r.data = ar_m;
				op_clear:   ar_m = '0;
				default: begin
					// store and fetch, stop on nomem
					r.data = ar_m;
					if (ar_m >= addr_t'(mem_words)) begin
						r.alarm = 1'b1;
					end else begin
						if (rows[i].cmd.op == op_store) begin
							mem_m[ar_m] = rows[i].cmd.data;
						end else begin
							r.data = mem_m.exists(ar_m) ? mem_m[ar_m] : '0;
						end
						ar_m = ar_m + 16'd1;
					end
				end
			endcase
			if (r !== rows[i].exp) begin
				fail_count++;
				$display("table row %s does not follow the panel rules", rows[i].name);
			end
		end
	endtask

	// ------------------------------
	// processes
	// ------------------------------

	task automatic watchdog;
		while (cycles < cycle_limit) begin
			@(posedge CLK_EXT);
			cycles <= cycles + 1;
		end
		$display("run timed out after %0d cycles, %0d of %0d results received",
			cycles, done_count, rows.size());
		$display("Test FAILED");
		$finish;
	endtask

	task automatic check_power_up;
		int   n;
		logic early;
		n     = 0;
		early = 1'b0;
		do begin
			@(negedge CLK_EXT);
			// clear level still counting
			if (n < clear_cycles && cmd_ready !== 1'b0) begin
				early = 1'b1;
			end
			n++;
		end while (pon !== 1'b1 && n < clear_cycles + 8);
		check_pon("power_on", 1'b1, pon);
		if (early) begin
			fail_count++;
			$display("cmd_ready went high while the clear period was still running");
		end
	endtask

	task automatic send_all;
		@(posedge CLK_EXT);
		#0.5;
		foreach (rows[i]) begin
			if (!rows[i].stall) begin
				// fixed latency rows go through an empty pipe
				cmd_valid = 1'b0;
				while (done_count < i) begin
					@(posedge CLK_EXT);
					#0.5;
				end
			end
			cmd       = rows[i].cmd;
			cmd_valid = 1'b1;
			do begin
				@(negedge CLK_EXT);
			end while (cmd_ready !== 1'b1);
			accept_cyc.push_back(cycles);
			@(posedge CLK_EXT);
			#0.5;
		end
		cmd_valid = 1'b0;
	endtask

	task automatic collect_all;
		panel_res_t got;
		int         lat;
		while (done_count < rows.size()) begin
			@(posedge CLK_EXT);
			#0.5;
			res_ready = rows[done_count].stall ? 1'($random(seed)) : 1'b1;
			@(negedge CLK_EXT);
			if (res_valid === 1'b1 && res_ready) begin
				got = res;
				lat = cycles - accept_cyc[done_count];
				check_res(rows[done_count].name, rows[done_count].exp, got);
				if (!rows[done_count].stall) begin
					if (rows[done_count].cmd.op == op_clear) begin
						// clear period plus a few pipeline cycles
						check_latency(rows[done_count].name, clear_cycles, clear_cycles + 8, lat);
					end else begin
						check_latency(rows[done_count].name,
							expected_latency(rows[done_count].exp),
							expected_latency(rows[done_count].exp), lat);
					end
				end
				done_count++;
			end
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		logic reset_bad;
		logic extra;
		CLK_EXT    = 1'b0;
		rst        = 1'b1;
		cmd        = '0;
		cmd_valid  = 1'b0;
		res_ready  = 1'b0;
		seed       = 16697;
		cycles     = 0;
		done_count = 0;
		pass_count = 0;
		fail_count = 0;
		reset_bad  = 1'b0;
		extra      = 1'b0;
		load_table();
		check_table();
		cycle_limit = 40 * rows.size() + 100;
		fork
			watchdog();
		join_none
		// 8 reset cycles, handshakes quiet
		for (int k = 0; k < 8; k++) begin
			@(posedge CLK_EXT);
			#0.5;
			if (cmd_ready !== 1'b0 || res_valid !== 1'b0) begin
				reset_bad = 1'b1;
			end
		end
		rst = 1'b0;
		if (reset_bad) begin
			fail_count++;
			$display("cmd_ready or res_valid was not low during reset");
		end
		check_power_up();
		fork
			send_all();
			collect_all();
		join
		// no result may follow the last one
		@(posedge CLK_EXT);
		#0.5;
		res_ready = 1'b1;
		repeat (8) begin
			@(negedge CLK_EXT);
			if (res_valid !== 1'b0) begin
				extra = 1'b1;
			end
		end
		if (extra) begin
			fail_count++;
			$display("a result appeared with no command left to answer");
		end
		$display("checks: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+dv
hw/mera_pkg.sv
hw/power_seq.sv
hw/panel_decode.sv
hw/bus_execute.sv
hw/main_mem.sv
hw/panel_result.sv
hw/mera_panel_top.sv
dv/tb_mera_panel.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing -Wno-fatal
TOP   = tb_mera_panel
FLIST = verilog.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
